// File: cpu_props.sv
/* pipeline control properties, bound into cpu_top. the running flag is
   taken from the divider instance. */
`timescale 1ns/1ps
`default_nettype none

module cpu_props import mips_pkg::*; (
    input logic                  clk,
    input logic                  rst_n_i,
    input logic                  start_i,
    input logic                  done_i,
    input logic                  div_running_i,
    input logic                  busy_i,
    input logic                  wb_en_i,
    input logic [REG_ADDR_W-1:0] wb_addr_i
);

    // a second start would restart the running divide
    no_start_while_pending: assert property (@(posedge clk) disable iff (!rst_n_i)
        (div_running_i || done_i) |-> !start_i)
        else $error("divide start raised while a divide is pending");

    busy_until_done: assert property (@(posedge clk) disable iff (!rst_n_i)
        busy_i |=> (busy_i || done_i))
        else $error("busy dropped before the divide finished");

    no_write_to_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_en_i |-> (wb_addr_i != '0))
        else $error("write enable raised for register 0");

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n_i |-> !wb_en_i)
        else $error("write enable high during reset");

endmodule

bind cpu_top cpu_props u_props (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .start_i       (div_bus.start),
    .done_i        (div_bus.done),
    .div_running_i (u_divider.running),
    .busy_i        (busy),
    .wb_en_i       (wb_en_o),
    .wb_addr_i     (wb_addr_o)
);

`default_nettype wire

// File: cpu_top.sv
/* five-stage integer pipeline top. no branches or memory access; the
   only stall is a running divide, which bubbles EX/MEM. */
`timescale 1ns/1ps
`default_nettype none

module cpu_top import mips_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic [XLEN-1:0]        inst_i,
    output logic [INST_ADDR_W-1:0] inst_addr_o,
    output logic                   wb_en_o,
    output logic [REG_ADDR_W-1:0]  wb_addr_o,
    output logic [XLEN-1:0]        wb_data_o
);

    if_id_t                if_id;
    id_ex_t                id_ex_d;
    id_ex_t                id_ex_q;
    wb_t                   ex_res;
    wb_t                   ex_mem;
    wb_t                   mem_wb;
    logic                  busy;
    logic [REG_ADDR_W-1:0] rd_addr_a;
    logic [REG_ADDR_W-1:0] rd_addr_b;
    logic [XLEN-1:0]       rd_data_a;
    logic [XLEN-1:0]       rd_data_b;
    logic [XLEN-1:0]       hi;
    logic [XLEN-1:0]       lo;

    div_if #(.W(XLEN)) div_bus ();

    fetch_unit u_fetch (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .hold_i      (busy),
        .inst_i      (inst_i),
        .inst_addr_o (inst_addr_o),
        .if_id_o     (if_id)
    );

    decode u_decode (
        .if_id_i     (if_id),
        .rd_addr_a_o (rd_addr_a),
        .rd_addr_b_o (rd_addr_b),
        .rd_data_a_i (rd_data_a),
        .rd_data_b_i (rd_data_b),
        .hi_i        (hi),
        .lo_i        (lo),
        .ex_fwd_i    (ex_res),
        .mem_fwd_i   (ex_mem),
        .id_ex_o     (id_ex_d)
    );

    reg_file u_regs (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rd_addr_a_i (rd_addr_a),
        .rd_addr_b_i (rd_addr_b),
        .rd_data_a_o (rd_data_a),
        .rd_data_b_o (rd_data_b),
        .hi_o        (hi),
        .lo_o        (lo),
        .wb_i        (mem_wb)
    );

    stage_reg #(.T(id_ex_t)) u_id_ex (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .hold_i   (busy),
        .bubble_i (1'b0),
        .d_i      (id_ex_d),
        .q_o      (id_ex_q)
    );

    execute u_execute (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .id_ex_i  (id_ex_q),
        .div      (div_bus.requester),
        .busy_o   (busy),
        .result_o (ex_res)
    );

    divider #(.DIV_W(XLEN)) u_divider (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .div     (div_bus.engine)
    );

    stage_reg #(.T(wb_t)) u_ex_mem (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .hold_i   (1'b0),
        .bubble_i (busy),
        .d_i      (ex_res),
        .q_o      (ex_mem)
    );

    // MEM has no work left, so EX/MEM feeds MEM/WB directly
    stage_reg #(.T(wb_t)) u_mem_wb (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .hold_i   (1'b0),
        .bubble_i (1'b0),
        .d_i      (ex_mem),
        .q_o      (mem_wb)
    );

    assign wb_en_o   = mem_wb.we;
    assign wb_addr_o = mem_wb.waddr;
    assign wb_data_o = mem_wb.wdata;

endmodule

`default_nettype wire

// File: decode.sv
/* combinational decode with operand forwarding. unsupported words become
   ALU_NOP with no write; the execute result beats EX/MEM when both match. */
`timescale 1ns/1ps
`default_nettype none

module decode import mips_pkg::*; (
    input  if_id_t                if_id_i,
    output logic [REG_ADDR_W-1:0] rd_addr_a_o,
    output logic [REG_ADDR_W-1:0] rd_addr_b_o,
    input  logic [XLEN-1:0]       rd_data_a_i,
    input  logic [XLEN-1:0]       rd_data_b_i,
    input  logic [XLEN-1:0]       hi_i,
    input  logic [XLEN-1:0]       lo_i,
    input  wb_t                   ex_fwd_i,
    input  wb_t                   mem_fwd_i,
    output id_ex_t                id_ex_o
);

    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [4:0]            shamt;
    logic [XLEN-1:0]       imm_sx;
    logic [XLEN-1:0]       imm_zx;
    logic [XLEN-1:0]       rs_val;
    logic [XLEN-1:0]       rt_val;
    logic [XLEN-1:0]       hi_val;
    logic [XLEN-1:0]       lo_val;
    alu_op_t               op;

    function automatic logic [XLEN-1:0] fwd_gpr(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       rf_val,
        input wb_t                   ex,
        input wb_t                   mem
    );
        if (addr == '0) begin
            return rf_val;
        end else if (ex.we && ex.waddr == addr) begin
            return ex.wdata;
        end else if (mem.we && mem.waddr == addr) begin
            return mem.wdata;
        end
        return rf_val;
    endfunction

    assign opcode = if_id_i.inst[31:26];
    assign rs     = if_id_i.inst[25:21];
    assign rt     = if_id_i.inst[20:16];
    assign rd     = if_id_i.inst[15:11];
    assign shamt  = if_id_i.inst[10:6];
    assign funct  = if_id_i.inst[5:0];
    assign imm_sx = {{(XLEN-16){if_id_i.inst[15]}}, if_id_i.inst[15:0]};
    assign imm_zx = {{(XLEN-16){1'b0}}, if_id_i.inst[15:0]};

    assign rd_addr_a_o = rs;
    assign rd_addr_b_o = rt;

    assign rs_val = fwd_gpr(rs, rd_data_a_i, ex_fwd_i, mem_fwd_i);
    assign rt_val = fwd_gpr(rt, rd_data_b_i, ex_fwd_i, mem_fwd_i);
    assign hi_val = ex_fwd_i.hilo_we ? ex_fwd_i.hi :
                    mem_fwd_i.hilo_we ? mem_fwd_i.hi : hi_i;
    assign lo_val = ex_fwd_i.hilo_we ? ex_fwd_i.lo :
                    mem_fwd_i.hilo_we ? mem_fwd_i.lo : lo_i;

    always_comb begin
        op = ALU_NOP;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU: op = ALU_ADD;
                    FN_SUBU: op = ALU_SUB;
                    FN_AND:  op = ALU_AND;
                    FN_OR:   op = ALU_OR;
                    FN_XOR:  op = ALU_XOR;
                    FN_NOR:  op = ALU_NOR;
                    FN_SLT:  op = ALU_SLT;
                    FN_SLTU: op = ALU_SLTU;
                    FN_SLL:  op = ALU_SLL;
                    FN_SRL:  op = ALU_SRL;
                    FN_SRA:  op = ALU_SRA;
                    FN_MFHI: op = ALU_MFHI;
                    FN_MFLO: op = ALU_MFLO;
                    FN_DIV:  op = ALU_DIV;
                    FN_DIVU: op = ALU_DIVU;
                    default: op = ALU_NOP;
                endcase
            end
            OP_ADDIU: op = ALU_ADD;
            OP_SLTI:  op = ALU_SLT;
            OP_SLTIU: op = ALU_SLTU;
            OP_ANDI:  op = ALU_AND;
            OP_ORI:   op = ALU_OR;
            OP_XORI:  op = ALU_XOR;
            OP_LUI:   op = ALU_LUI;
            default:  op = ALU_NOP;
        endcase
    end

    always_comb begin
        id_ex_o.alu_op = op;
        case (op)
            ALU_SLL, ALU_SRL, ALU_SRA: id_ex_o.op_a = {{(XLEN-5){1'b0}}, shamt};
            ALU_MFHI: id_ex_o.op_a = hi_val;
            ALU_MFLO: id_ex_o.op_a = lo_val;
            default:  id_ex_o.op_a = rs_val;
        endcase
        if (opcode == OP_SPECIAL) begin
            id_ex_o.op_b  = rt_val;
            id_ex_o.waddr = rd;
        end else begin
            // arithmetic immediates sign-extend, logical ones zero-extend
            id_ex_o.op_b  = (opcode inside {OP_ADDIU, OP_SLTI, OP_SLTIU}) ? imm_sx : imm_zx;
            id_ex_o.waddr = rt;
        end
        id_ex_o.we = !(op inside {ALU_NOP, ALU_DIV, ALU_DIVU}) && (id_ex_o.waddr != '0);
    end

endmodule

`default_nettype wire

// File: div_if.sv
/* divider request and result bundle. start and done are single-cycle
   pulses; quotient and remainder are only valid while done is high. */
`timescale 1ns/1ps
`default_nettype none

interface div_if #(
    parameter int W = 32
);
    logic         start;
    logic         is_signed;
    logic [W-1:0] dividend;
    logic [W-1:0] divisor;
    logic [W-1:0] quotient;
    logic [W-1:0] remainder;
    logic         done;

    modport requester (
        output start, is_signed, dividend, divisor,
        input  quotient, remainder, done
    );

    modport engine (
        input  start, is_signed, dividend, divisor,
        output quotient, remainder, done
    );
endinterface

`default_nettype wire

// File: divider.sv
/* restoring divider, one quotient bit per cycle; done comes DIV_W+1 cycles
   after start. divide by zero yields an all-ones magnitude quotient. */
`timescale 1ns/1ps
`default_nettype none

module divider #(
    parameter int DIV_W = 32
) (
    input  logic clk,
    input  logic rst_n_i,
    div_if.engine div
);

    localparam int CNT_W = $clog2(DIV_W + 1);

    logic             running;
    logic             done_q;
    logic [CNT_W-1:0] cnt;
    logic [DIV_W-1:0] rem;
    logic [DIV_W-1:0] quo;
    logic [DIV_W-1:0] dvs;
    logic [DIV_W-1:0] mag_a;
    logic [DIV_W-1:0] mag_b;
    logic             neg_q;
    logic             neg_r;
    logic [DIV_W:0]   shifted;
    logic [DIV_W:0]   diff;

    assign mag_a = (div.is_signed && div.dividend[DIV_W-1]) ? -div.dividend : div.dividend;
    assign mag_b = (div.is_signed && div.divisor[DIV_W-1]) ? -div.divisor : div.divisor;

    // top bit of diff set means the trial subtract went negative
    assign shifted = {rem, quo[DIV_W-1]};
    assign diff    = shifted - {1'b0, dvs};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            running <= 1'b0;
            done_q  <= 1'b0;
            cnt     <= '0;
        end else begin
            done_q <= 1'b0;
            if (div.start) begin
                running <= 1'b1;
                cnt     <= CNT_W'(DIV_W);
            end else if (running) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin
                    running <= 1'b0;
                    done_q  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div.start) begin
            rem   <= '0;
            quo   <= mag_a;
            dvs   <= mag_b;
            neg_q <= div.is_signed && (div.dividend[DIV_W-1] ^ div.divisor[DIV_W-1]);
            neg_r <= div.is_signed && div.dividend[DIV_W-1];
        end else if (running) begin
            if (diff[DIV_W]) begin
                rem <= shifted[DIV_W-1:0];
                quo <= {quo[DIV_W-2:0], 1'b0};
            end else begin
                rem <= diff[DIV_W-1:0];
                quo <= {quo[DIV_W-2:0], 1'b1};
            end
        end
    end

    assign div.quotient  = neg_q ? -quo : quo;
    assign div.remainder = neg_r ? -rem : rem;
    assign div.done      = done_q;

endmodule

`default_nettype wire

// File: execute.sv
/* ALU and divide issue. busy_o is combinational and drops in the done
   cycle, when the quotient and remainder leave as a LO/HI write. */
`timescale 1ns/1ps
`default_nettype none

module execute import mips_pkg::*; (
    input  logic   clk,
    input  logic   rst_n_i,
    input  id_ex_t id_ex_i,
    div_if.requester div,
    output logic   busy_o,
    output wb_t    result_o
);

    logic            is_div;
    logic            pending;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] alu_res;

    assign a      = id_ex_i.op_a;
    assign b      = id_ex_i.op_b;
    assign is_div = id_ex_i.alu_op inside {ALU_DIV, ALU_DIVU};

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:  alu_res = a + b;
            ALU_SUB:  alu_res = a - b;
            ALU_AND:  alu_res = a & b;
            ALU_OR:   alu_res = a | b;
            ALU_XOR:  alu_res = a ^ b;
            ALU_NOR:  alu_res = ~(a | b);
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, a < b};
            // shift amount arrives in op_a
            ALU_SLL:  alu_res = b << a[4:0];
            ALU_SRL:  alu_res = b >> a[4:0];
            ALU_SRA:  alu_res = $unsigned($signed(b) >>> a[4:0]);
            ALU_LUI:  alu_res = {b[15:0], 16'h0000};
            ALU_MFHI, ALU_MFLO: alu_res = a;
            default:  alu_res = '0;
        endcase
    end

    // one start per divide, even while the stage is held
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending <= 1'b0;
        end else if (div.start) begin
            pending <= 1'b1;
        end else if (div.done) begin
            pending <= 1'b0;
        end
    end

    assign div.start     = is_div && !pending;
    assign div.is_signed = (id_ex_i.alu_op == ALU_DIV);
    assign div.dividend  = a;
    assign div.divisor   = b;
    assign busy_o        = is_div && !div.done;

    assign result_o.we      = id_ex_i.we;
    assign result_o.waddr   = id_ex_i.waddr;
    assign result_o.wdata   = alu_res;
    assign result_o.hilo_we = is_div && div.done;
    assign result_o.hi      = div.remainder;
    assign result_o.lo      = div.quotient;

endmodule

`default_nettype wire

// File: fetch_unit.sv
/* program counter and IF/ID. instruction memory must answer the word
   address combinationally within the same cycle. */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import mips_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   hold_i,
    input  logic [XLEN-1:0]        inst_i,
    output logic [INST_ADDR_W-1:0] inst_addr_o,
    output if_id_t                 if_id_o
);

    logic [XLEN-1:0] pc;
    if_id_t          if_id_d;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc <= RESET_PC;
        end else if (!hold_i) begin
            pc <= pc + XLEN'(4);
        end
    end

    // byte address to word address
    assign inst_addr_o  = pc[INST_ADDR_W+1:2];
    assign if_id_d.pc   = pc;
    assign if_id_d.inst = inst_i;

    stage_reg #(.T(if_id_t)) u_if_id (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .hold_i   (hold_i),
        .bubble_i (1'b0),
        .d_i      (if_id_d),
        .q_o      (if_id_o)
    );

endmodule

`default_nettype wire

// File: mips_pkg.sv
/* shared widths, encodings and stage payloads for the integer pipeline.
   alu_op_t value zero is the no-op, so an all-zero payload is a bubble. */
`default_nettype none

package mips_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int INST_ADDR_W = 20;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // function field of OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_MFHI = 6'h10;
    localparam logic [5:0] FN_MFLO = 6'h12;
    localparam logic [5:0] FN_DIV  = 6'h1a;
    localparam logic [5:0] FN_DIVU = 6'h1b;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef enum logic [4:0] {
        ALU_NOP = 5'd0, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
        ALU_MFHI, ALU_MFLO, ALU_DIV, ALU_DIVU
    } alu_op_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
    } id_ex_t;

    // shared by EX/MEM and MEM/WB
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
        logic                  hilo_we;
        logic [XLEN-1:0]       hi;
        logic [XLEN-1:0]       lo;
    } wb_t;

endpackage

`default_nettype wire

// File: reg_file.sv
/* 32 GPRs and HI/LO. a write in WB is visible to a read in the same
   cycle; register 0 is never written. */
`timescale 1ns/1ps
`default_nettype none

module reg_file import mips_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_a_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_b_i,
    output logic [XLEN-1:0]       rd_data_a_o,
    output logic [XLEN-1:0]       rd_data_b_o,
    output logic [XLEN-1:0]       hi_o,
    output logic [XLEN-1:0]       lo_o,
    input  wb_t                   wb_i
);

    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] hi_q;
    logic [XLEN-1:0] lo_q;
    logic            gpr_we;

    assign gpr_we = wb_i.we && (wb_i.waddr != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (gpr_we) begin
                regs[wb_i.waddr] <= wb_i.wdata;
            end
            if (wb_i.hilo_we) begin
                hi_q <= wb_i.hi;
                lo_q <= wb_i.lo;
            end
        end
    end

    // write-through bypass
    assign rd_data_a_o = (gpr_we && wb_i.waddr == rd_addr_a_i) ? wb_i.wdata : regs[rd_addr_a_i];
    assign rd_data_b_o = (gpr_we && wb_i.waddr == rd_addr_b_i) ? wb_i.wdata : regs[rd_addr_b_i];
    assign hi_o        = wb_i.hilo_we ? wb_i.hi : hi_q;
    assign lo_o        = wb_i.hilo_we ? wb_i.lo : lo_q;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds tb_cpu with Verilator, runs it and scans the log; exit status 1 means failure
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f sources.f -o tb_cpu \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_cpu > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q -e "%Error" -e "Assertion failed" sim.log && { echo "FAIL: assertion error"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL: run ended early"; exit 1; }
echo "PASS"

// File: sources.f
mips_pkg.sv
div_if.sv
stage_reg.sv
fetch_unit.sv
reg_file.sv
decode.sv
execute.sv
divider.sv
cpu_top.sv
cpu_props.sv
tb_cpu.sv

// File: stage_reg.sv
/* pipeline register for any packed payload. bubble_i wins over hold_i;
   the zero payload must decode as a no-op. */
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic hold_i,
    input  logic bubble_i,
    input  T     d_i,
    output T     q_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (bubble_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

// File: tb_cpu.sv
/* random-program testbench for cpu_top. expected GPR writes come from an
   in-order ISA model; HI/LO are only observed through MFHI and MFLO. */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import mips_pkg::*; ();

    localparam int CLK_PERIOD  = 8;
    localparam int DRIVE_DLY   = 1;
    localparam int PROG_LEN    = 300;
    localparam int MEM_AW      = 9;
    localparam int MEM_WORDS   = 1 << MEM_AW;
    localparam int TAIL_WORDS  = 16;
    // worst case every instruction pays a full divide plus pipeline fill
    localparam int TIMEOUT_CYC = PROG_LEN * (XLEN + 4) + 200;

    logic                   clk;
    logic                   rst_n_i;
    logic [XLEN-1:0]        inst_i;
    logic [INST_ADDR_W-1:0] inst_addr_o;
    logic                   wb_en_o;
    logic [REG_ADDR_W-1:0]  wb_addr_o;
    logic [XLEN-1:0]        wb_data_o;

    logic [XLEN-1:0]       imem [MEM_WORDS];
    logic [XLEN-1:0]       m_regs [32];
    logic [XLEN-1:0]       m_hi;
    logic [XLEN-1:0]       m_lo;
    logic [REG_ADDR_W-1:0] exp_addr_q [$];
    logic [XLEN-1:0]       exp_data_q [$];
    int                    seed = 76;
    int                    prog_cnt = 0;
    int                    expected_total = 0;
    int                    writes_seen = 0;
    int                    mismatch_errs = 0;
    int                    other_errs = 0;

    // memory answers combinationally, no-ops above the array
    assign inst_i = (inst_addr_o < INST_ADDR_W'(MEM_WORDS)) ? imem[inst_addr_o[MEM_AW-1:0]] : '0;

    cpu_top dut_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .inst_i      (inst_i),
        .inst_addr_o (inst_addr_o),
        .wb_en_o     (wb_en_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o)
    );

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'(rand_below(8));
    endfunction

    function automatic logic [XLEN-1:0] encode_rtype(input logic [5:0] fn, input logic [4:0] rs,
                                                     input logic [4:0] rt, input logic [4:0] rd,
                                                     input logic [4:0] sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [XLEN-1:0] encode_itype(input logic [5:0] op, input logic [4:0] rs,
                                                     input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic place(input logic [XLEN-1:0] word);
        if (prog_cnt < PROG_LEN) begin
            imem[prog_cnt] = word;
        end
        prog_cnt++;
    endtask

    task automatic build_program();
        logic [5:0]  alu_fns [8];
        logic [5:0]  sh_fns [3];
        logic [5:0]  imm_ops [7];
        logic [5:0]  bad_ops [4];
        logic [5:0]  fn;
        logic [5:0]  dfn;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rc;
        logic [4:0]  sa;
        logic [15:0] imm;
        int unsigned kind;
        alu_fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
        sh_fns  = '{FN_SLL, FN_SRL, FN_SRA};
        imm_ops = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        // jump, branch, load and store opcodes
        bad_ops = '{6'h02, 6'h04, 6'h23, 6'h2b};
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
        end
        // full 32-bit values in r1..r7
        for (int r = 1; r < 8; r++) begin
            place(encode_itype(OP_LUI, 5'd0, 5'(r), 16'(rand_below(65536))));
            place(encode_itype(OP_ORI, 5'(r), 5'(r), 16'(rand_below(65536))));
        end
        while (prog_cnt < PROG_LEN) begin
            kind = rand_below(16);
            ra   = pick_reg();
            rb   = pick_reg();
            rc   = pick_reg();
            sa   = 5'(rand_below(32));
            imm  = 16'(rand_below(65536));
            dfn  = (rand_below(2) == 0) ? FN_DIV : FN_DIVU;
            case (kind)
                0, 1, 2, 3, 4: begin
                    fn = alu_fns[rand_below(8)];
                    place(encode_rtype(fn, ra, rb, rc, 5'd0));
                end
                5, 6: begin
                    fn = sh_fns[rand_below(3)];
                    place(encode_rtype(fn, 5'd0, rb, rc, sa));
                end
                7, 8, 9: place(encode_itype(imm_ops[rand_below(7)], ra, rb, imm));
                10: begin
                    place(encode_rtype(dfn, ra, rb, 5'd0, 5'd0));
                    place(encode_rtype(FN_MFLO, 5'd0, 5'd0, rc, 5'd0));
                    place(encode_rtype(FN_MFHI, 5'd0, 5'd0, ra, 5'd0));
                end
                11: begin
                    // divisor taken from r0
                    place(encode_rtype(dfn, ra, 5'd0, 5'd0, 5'd0));
                    place(encode_rtype(FN_MFHI, 5'd0, 5'd0, rc, 5'd0));
                    place(encode_rtype(FN_MFLO, 5'd0, 5'd0, rb, 5'd0));
                end
                12: begin
                    // most negative value over minus one
                    ra = 5'(1 + rand_below(3));
                    rb = 5'(4 + rand_below(4));
                    place(encode_itype(OP_LUI, 5'd0, ra, 16'h8000));
                    place(encode_itype(OP_ADDIU, 5'd0, rb, 16'hffff));
                    place(encode_rtype(dfn, ra, rb, 5'd0, 5'd0));
                    place(encode_rtype(FN_MFLO, 5'd0, 5'd0, rc, 5'd0));
                    place(encode_rtype(FN_MFHI, 5'd0, 5'd0, ra, 5'd0));
                end
                13: begin
                    fn = (rand_below(2) == 0) ? FN_MFHI : FN_MFLO;
                    place(encode_rtype(fn, 5'd0, 5'd0, rc, 5'd0));
                end
                14: place({bad_ops[rand_below(4)], 26'($random(seed))});
                default: begin
                    // MULT is outside the set, then a dependent pair
                    place(encode_rtype(6'h18, ra, rb, rc, 5'd0));
                    place(encode_itype(OP_ADDIU, rc, rc, imm));
                    place(encode_rtype(FN_ADDU, rc, ra, rc, 5'd0));
                end
            endcase
        end
    endtask

    task automatic model_divide(input logic [XLEN-1:0] n, input logic [XLEN-1:0] d,
                                input logic sgn, output logic [XLEN-1:0] quo,
                                output logic [XLEN-1:0] rem);
        logic            neg_n;
        logic            neg_d;
        logic [XLEN-1:0] mag_n;
        logic [XLEN-1:0] mag_d;
        logic [XLEN-1:0] q_mag;
        logic [XLEN-1:0] r_mag;
        neg_n = sgn && n[XLEN-1];
        neg_d = sgn && d[XLEN-1];
        mag_n = neg_n ? -n : n;
        mag_d = neg_d ? -d : d;
        if (mag_d == '0) begin
            q_mag = '1;
            r_mag = mag_n;
        end else begin
            q_mag = mag_n / mag_d;
            r_mag = mag_n % mag_d;
        end
        quo = (neg_n != neg_d) ? -q_mag : q_mag;
        rem = neg_n ? -r_mag : r_mag;
    endtask

    task automatic run_model();
        logic [XLEN-1:0] w;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] sx;
        logic [XLEN-1:0] zx;
        logic [XLEN-1:0] res;
        logic [4:0]      dst;
        logic            wr;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        m_hi = '0;
        m_lo = '0;
        for (int pc = 0; pc < PROG_LEN; pc++) begin
            w   = imem[pc];
            a   = m_regs[w[25:21]];
            b   = m_regs[w[20:16]];
            sx  = {{16{w[15]}}, w[15:0]};
            zx  = {16'h0000, w[15:0]};
            res = '0;
            wr  = 1'b1;
            dst = w[15:11];
            if (w[31:26] == OP_SPECIAL) begin
                case (w[5:0])
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_NOR:  res = ~(a | b);
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    FN_SLL:  res = b << w[10:6];
                    FN_SRL:  res = b >> w[10:6];
                    FN_SRA:  res = $unsigned($signed(b) >>> w[10:6]);
                    FN_MFHI: res = m_hi;
                    FN_MFLO: res = m_lo;
                    FN_DIV, FN_DIVU: begin
                        wr = 1'b0;
                        model_divide(a, b, w[5:0] == FN_DIV, m_lo, m_hi);
                    end
                    default: wr = 1'b0;
                endcase
            end else begin
                dst = w[20:16];
                case (w[31:26])
                    OP_ADDIU: res = a + sx;
                    OP_SLTI:  res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
                    OP_SLTIU: res = (a < sx) ? 32'd1 : 32'd0;
                    OP_ANDI:  res = a & zx;
                    OP_ORI:   res = a | zx;
                    OP_XORI:  res = a ^ zx;
                    OP_LUI:   res = {w[15:0], 16'h0000};
                    default:  wr = 1'b0;
                endcase
            end
            if (wr && dst != 5'd0) begin
                m_regs[dst] = res;
                exp_addr_q.push_back(dst);
                exp_data_q.push_back(res);
            end
        end
    endtask

    task automatic check_write();
        logic [REG_ADDR_W-1:0] exp_addr;
        logic [XLEN-1:0]       exp_data;
        assert (wb_addr_o != '0) else begin
            other_errs++;
            $display("%0t: a write to register 0 reached the write-back port", $time);
        end
        assert (exp_addr_q.size() != 0) else begin
            other_errs++;
            $display("%0t: extra write to r%0d after all expected writes", $time, wb_addr_o);
        end
        if (exp_addr_q.size() != 0) begin
            exp_addr = exp_addr_q.pop_front();
            exp_data = exp_data_q.pop_front();
            assert (wb_addr_o == exp_addr) else begin
                mismatch_errs++;
                $display("MISMATCH at %0t: wb_addr_o expected %0d, got %0d",
                         $time, exp_addr, wb_addr_o);
            end
            assert (wb_data_o == exp_data) else begin
                mismatch_errs++;
                $display("MISMATCH at %0t: wb_data_o expected %h, got %h",
                         $time, exp_data, wb_data_o);
            end
        end
    endtask

    task automatic finish_run();
        $display("writes checked: %0d, mismatches: %0d, other errors: %0d",
                 writes_seen, mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // write port sampled mid-cycle
    always @(negedge clk) begin
        if (!rst_n_i) begin
            assert (!wb_en_o) else begin
                other_errs++;
                $display("%0t: write port active during reset", $time);
            end
        end else if (wb_en_o) begin
            writes_seen++;
            check_write();
        end
    end

    initial begin
        rst_n_i = 1'b0;
        build_program();
        run_model();
        expected_total = exp_addr_q.size();
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst_n_i = 1'b1;
        assert (inst_addr_o == '0) else begin
            mismatch_errs++;
            $display("MISMATCH at %0t: inst_addr_o expected 0, got %h", $time, inst_addr_o);
        end
        // every program word has retired once fetch runs this far past the end
        while (inst_addr_o < INST_ADDR_W'(PROG_LEN + TAIL_WORDS)) begin
            @(negedge clk);
        end
        assert (exp_addr_q.size() == 0) else begin
            other_errs++;
            $display("%0d expected register writes never retired", exp_addr_q.size());
        end
        finish_run();
    end

    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        other_errs++;
        $display("timeout after %0d cycles with %0d of %0d writes retired",
                 TIMEOUT_CYC, writes_seen, expected_total);
        finish_run();
    end

endmodule

`default_nettype wire
